// File: Makefile
VERILATOR   ?= verilator
TOP         := map_switch_tb
FILELIST    := src.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --timing -Wno-fatal -j 0
LINT_FLAGS  := --lint-only --timing -Wall
PASS_MSG    := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/game_pkg.sv
package game_pkg;

    localparam int NUM_LEVELS = 5;
    localparam int KEY_W      = 10;
    localparam int COORD_W    = 10;
    localparam int ADDR_W     = 17;

    // Menu image geometry, in half-resolution beam units
    localparam int ROW_PITCH     = 320;
    localparam int MENU_ROW_TOP0 = 40;
    localparam int MENU_ROW_STEP = 40;
    localparam int MENU_ROW_H    = 25;
    localparam int MENU_X0       = 150;
    localparam int MENU_X_SEL    = 148;  // Arrow makes the highlighted row wider
    localparam int MENU_X_END    = 170;
    localparam int SEL_OFFSET    = 127;  // Arrow graphic sits further left in the image

    localparam int RISE_CYCLES_DEF = 70_000_000;
    localparam int FALL_CYCLES_DEF = 240_000_000;
    localparam int JUMP_CNT_W      = 30;

    typedef logic [2:0] level_t;  // Valid range is 1 to NUM_LEVELS

    typedef enum logic {
        PHASE_MENU,
        PHASE_PLAY
    } phase_e;

    // Codes 6 to 9 are what the sprite renderer expects
    typedef enum logic [3:0] {
        FACE_STILL = 4'd6,
        FACE_RIGHT = 4'd7,
        FACE_LEFT  = 4'd8,
        FACE_UP    = 4'd9
    } facing_e;

    typedef enum logic [1:0] {
        JUMP_GROUND = 2'd0,
        JUMP_RISE   = 2'd1,
        JUMP_FALL   = 2'd2
    } jump_e;

    typedef struct packed {
        logic jump;
        logic left;
        logic down;
        logic right;
    } player_keys_t;

    typedef struct packed {
        logic collision;    // Head hit something while rising
        logic land;         // Feet on a platform
        logic should_down;  // Walked off an edge
    } terrain_t;

    typedef struct packed {
        facing_e facing;
        jump_e   jump;
    } motion_t;

endpackage

// File: hdl/level_menu.sv
`timescale 1ns/1ps

module level_menu (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [game_pkg::KEY_W-1:0] key_down,
    output game_pkg::level_t           level,
    output game_pkg::phase_e           phase,
    output logic                       flag_cover
);

    import game_pkg::*;

    logic key_open;  // Lock that limits each press to a single step
    logic key_next;
    logic key_prev;
    logic key_start;

    // Both players can drive the menu
    assign key_next  = key_down[0] | key_down[4];
    assign key_prev  = key_down[2] | key_down[6];
    assign key_start = key_down[8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            level      <= level_t'(1);
            phase      <= PHASE_MENU;
            flag_cover <= 1'b1;
            key_open   <= 1'b1;
        end else if (phase == PHASE_MENU) begin
            if (key_down == '0) begin
                key_open <= 1'b1;  // All keys released
            end else if (key_open) begin
                if (key_next) begin
                    if (level < level_t'(NUM_LEVELS)) begin
                        level <= level + level_t'(1);
                    end
                    key_open <= 1'b0;
                end else if (key_prev) begin
                    if (level > level_t'(1)) begin
                        level <= level - level_t'(1);
                    end
                    key_open <= 1'b0;
                end else if (key_start) begin
                    // First press dismisses the cover, the next one starts play
                    if (flag_cover) begin
                        flag_cover <= 1'b0;
                    end else begin
                        phase <= PHASE_PLAY;
                    end
                    key_open <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hdl/map_switch.sv
`timescale 1ns/1ps

module map_switch #(
    parameter int RISE_CYCLES = game_pkg::RISE_CYCLES_DEF,
    parameter int FALL_CYCLES = game_pkg::FALL_CYCLES_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [game_pkg::KEY_W-1:0]   key_down,
    input  logic [game_pkg::COORD_W-1:0] vga_h,
    input  logic [game_pkg::COORD_W-1:0] vga_v,
    input  logic [15:0]                  cover_addr,
    input  logic [game_pkg::ADDR_W-1:0]  map_addr,
    input  game_pkg::terrain_t           p1_env,
    input  game_pkg::terrain_t           p2_env,
    output logic [game_pkg::ADDR_W-1:0]  pixel_addr,
    output game_pkg::motion_t            p1_motion,
    output game_pkg::motion_t            p2_motion,
    output game_pkg::level_t             level,
    output game_pkg::phase_e             phase,
    output logic                         flag_cover
);

    import game_pkg::*;

    player_keys_t      p1_keys;
    player_keys_t      p2_keys;
    logic              active;
    logic [ADDR_W-1:0] menu_addr;

    // Player 1 uses the upper key group, player 2 the lower one
    assign p1_keys = '{jump: key_down[4], left: key_down[5], down: key_down[6],
                       right: key_down[7]};
    assign p2_keys = '{jump: key_down[0], left: key_down[1], down: key_down[2],
                       right: key_down[3]};

    assign active = (phase == PHASE_PLAY);

    level_menu u_menu (
        .clk        (clk),
        .rst        (rst),
        .key_down   (key_down),
        .level      (level),
        .phase      (phase),
        .flag_cover (flag_cover)
    );

    player_motion #(.RISE_CYCLES(RISE_CYCLES), .FALL_CYCLES(FALL_CYCLES)) u_p1 (
        .clk     (clk),
        .rst     (rst),
        .active  (active),
        .keys    (p1_keys),
        .terrain (p1_env),
        .motion  (p1_motion)
    );

    player_motion #(.RISE_CYCLES(RISE_CYCLES), .FALL_CYCLES(FALL_CYCLES)) u_p2 (
        .clk     (clk),
        .rst     (rst),
        .active  (active),
        .keys    (p2_keys),
        .terrain (p2_env),
        .motion  (p2_motion)
    );

    menu_cursor_addr u_cursor (
        .vga_h (vga_h),
        .vga_v (vga_v),
        .level (level),
        .addr  (menu_addr)
    );

    always_comb begin
        if (flag_cover) begin
            pixel_addr = ADDR_W'(cover_addr);
        end else if (phase == PHASE_MENU) begin
            pixel_addr = menu_addr;
        end else if (level == level_t'(1)) begin
            pixel_addr = map_addr;
        end else begin
            pixel_addr = '0;  // Only level 1 has a map renderer
        end
    end

endmodule

// File: hdl/menu_cursor_addr.sv
`timescale 1ns/1ps

module menu_cursor_addr (
    input  logic [game_pkg::COORD_W-1:0] vga_h,
    input  logic [game_pkg::COORD_W-1:0] vga_v,
    input  game_pkg::level_t             level,
    output logic [game_pkg::ADDR_W-1:0]  addr
);

    import game_pkg::*;

    logic [COORD_W-1:0] h;
    logic [COORD_W-1:0] v;
    int                 sel_band;

    // Menu image is drawn at half resolution
    assign h = vga_h >> 1;
    assign v = vga_v >> 1;

    // Level 1 sits in the bottom band
    assign sel_band = NUM_LEVELS - int'(level);

    always_comb begin
        int top;
        int hi;
        int vi;
        addr = '0;
        hi   = int'(h);
        vi   = int'(v);
        for (int b = 0; b < NUM_LEVELS; b++) begin
            top = MENU_ROW_TOP0 + b * MENU_ROW_STEP;
            if (vi >= top && vi < top + MENU_ROW_H) begin
                if (b == sel_band) begin
                    if (hi >= MENU_X_SEL && hi < MENU_X_END) begin
                        addr = ADDR_W'((hi - SEL_OFFSET) + (vi - top + 1) * ROW_PITCH);
                    end
                end else if (hi >= MENU_X0 && hi < MENU_X_END) begin
                    addr = ADDR_W'((hi - MENU_X0) + (vi - top + 1) * ROW_PITCH);
                end
            end
        end
    end

endmodule

// File: hdl/player_motion.sv
`timescale 1ns/1ps

module player_motion #(
    parameter int RISE_CYCLES = game_pkg::RISE_CYCLES_DEF,
    parameter int FALL_CYCLES = game_pkg::FALL_CYCLES_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   active,
    input  game_pkg::player_keys_t keys,
    input  game_pkg::terrain_t     terrain,
    output game_pkg::motion_t      motion
);

    import game_pkg::*;

    facing_e               facing_q;
    facing_e               facing_d;
    jump_e                 jump_q;
    jump_e                 jump_d;
    logic [JUMP_CNT_W-1:0] cnt_q;
    logic [JUMP_CNT_W-1:0] cnt_d;

    logic airborne;
    logic any_key;
    logic jump_only;
    logic go_left;
    logic go_right;
    logic do_step;     // Advance the rise/fall timer this cycle
    logic force_fall;  // Skip the rise check
    logic rise_ok;
    logic fall_done;

    assign airborne  = (jump_q != JUMP_GROUND);
    assign any_key   = keys.jump | keys.left | keys.down | keys.right;
    assign jump_only = keys.jump & ~keys.left & ~keys.down & ~keys.right;
    assign go_left   = (keys.left | keys.jump) & ~keys.right;
    assign go_right  = (keys.right | keys.jump) & ~keys.left;

    assign rise_ok   = (cnt_q < JUMP_CNT_W'(RISE_CYCLES)) && !terrain.collision
                       && (jump_q != JUMP_FALL);
    assign fall_done = (cnt_q >= JUMP_CNT_W'(FALL_CYCLES)) || terrain.land;

    // Facing follows the keys; decide whether the timer moves
    always_comb begin
        facing_d   = facing_q;
        do_step    = airborne;
        force_fall = 1'b0;
        if (!any_key) begin
            if (!airborne) begin
                facing_d = FACE_STILL;
            end
        end else if (jump_only) begin
            facing_d = FACE_UP;
            do_step  = 1'b1;
        end else if (go_left || go_right) begin
            facing_d   = go_left ? FACE_LEFT : FACE_RIGHT;
            do_step    = keys.jump | airborne | terrain.should_down;
            force_fall = terrain.should_down;
        end
    end

    // Rise until the limit or a ceiling, then fall until landing or timeout
    always_comb begin
        jump_d = jump_q;
        cnt_d  = cnt_q;
        if (do_step) begin
            if (rise_ok && !force_fall) begin
                jump_d = JUMP_RISE;
                cnt_d  = cnt_q + 1'b1;
            end else if (!fall_done) begin
                jump_d = JUMP_FALL;
                cnt_d  = cnt_q + 1'b1;
            end else begin
                jump_d = JUMP_GROUND;
                cnt_d  = '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            facing_q <= FACE_STILL;
            jump_q   <= JUMP_GROUND;
            cnt_q    <= '0;
        end else if (!active) begin
            facing_q <= FACE_STILL;  // Players are parked outside play
            jump_q   <= JUMP_GROUND;
            cnt_q    <= '0;
        end else begin
            facing_q <= facing_d;
            jump_q   <= jump_d;
            cnt_q    <= cnt_d;
        end
    end

    assign motion = '{facing: facing_q, jump: jump_q};

endmodule

// File: src.f
hdl/game_pkg.sv
hdl/level_menu.sv
hdl/player_motion.sv
hdl/menu_cursor_addr.sv
hdl/map_switch.sv
verif/map_switch_tb.sv

// File: verif/map_switch_tb.sv
`timescale 1ns/1ps

module map_switch_tb;

    import game_pkg::*;

    localparam int RISE_CYCLES = 8;
    localparam int FALL_CYCLES = 20;
    localparam int AIR_CYCLES  = RISE_CYCLES + FALL_CYCLES + 4;  // Longest jump plus slack
    localparam int STIM_CYCLES = 16 + 400 + NUM_LEVELS * 405 + 8 * AIR_CYCLES + 600;

    typedef struct packed {
        motion_t m;
        int      cnt;
    } player_t;

    logic               clk;
    logic               rst;
    logic [KEY_W-1:0]   key_down;
    logic [COORD_W-1:0] vga_h;
    logic [COORD_W-1:0] vga_v;
    logic [15:0]        cover_addr;
    logic [ADDR_W-1:0]  map_addr;
    terrain_t           p1_env;
    terrain_t           p2_env;
    logic [ADDR_W-1:0]  pixel_addr;
    motion_t            p1_motion;
    motion_t            p2_motion;
    level_t             level;
    phase_e             phase;
    logic               flag_cover;
    logic [31:0]        rng;
    level_t             m_level;  // Reference model state
    phase_e             m_phase;
    logic               m_cover;
    logic               m_open;
    player_t            m_p1;
    player_t            m_p2;
    logic [ADDR_W-1:0]  exp_addr;

    map_switch #(.RISE_CYCLES(RISE_CYCLES), .FALL_CYCLES(FALL_CYCLES)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic player_keys_t key_group(input logic [KEY_W-1:0] k, input int base);
        key_group = '{jump: k[base], left: k[base+1], down: k[base+2], right: k[base+3]};
    endfunction

    // Level 1 highlights the bottom row of the menu
    function automatic logic [ADDR_W-1:0] cursor_ref(input logic [COORD_W-1:0] bh,
                                                     input logic [COORD_W-1:0] bv,
                                                     input level_t lv);
        int   x;
        int   y;
        int   band;
        int   top;
        logic sel;
        x          = int'(bh) / 2;
        y          = int'(bv) / 2;
        band       = (y - MENU_ROW_TOP0) / MENU_ROW_STEP;
        top        = MENU_ROW_TOP0 + band * MENU_ROW_STEP;
        sel        = (band == NUM_LEVELS - int'(lv));
        cursor_ref = '0;
        if (y >= MENU_ROW_TOP0 && band < NUM_LEVELS && y < top + MENU_ROW_H) begin
            if (sel && x >= MENU_X_SEL && x < MENU_X_END) begin
                cursor_ref = ADDR_W'((x - SEL_OFFSET) + (y - top + 1) * ROW_PITCH);
            end else if (!sel && x >= MENU_X0 && x < MENU_X_END) begin
                cursor_ref = ADDR_W'((x - MENU_X0) + (y - top + 1) * ROW_PITCH);
            end
        end
    endfunction

    function automatic player_t motion_ref(input player_t s, input logic act,
                                           input player_keys_t k, input terrain_t t);
        player_t n;
        logic    air;
        logic    up_only;
        logic    side;
        logic    forced;
        n       = s;
        air     = (s.m.jump != JUMP_GROUND);
        up_only = (k == 4'b1000);  // Jump key alone
        side    = ((k.left || k.jump) && !k.right) || ((k.right || k.jump) && !k.left);
        forced  = side && !up_only && t.should_down;
        if (k == '0 && !air) n.m.facing = FACE_STILL;
        else if (up_only) n.m.facing = FACE_UP;
        else if ((k.left || k.jump) && !k.right) n.m.facing = FACE_LEFT;
        else if (side) n.m.facing = FACE_RIGHT;
        if (air || up_only || (side && (k.jump || t.should_down))) begin
            if (!forced && s.m.jump != JUMP_FALL && s.cnt < RISE_CYCLES && !t.collision) begin
                n.m.jump = JUMP_RISE;
                n.cnt    = s.cnt + 1;
            end else if (s.cnt < FALL_CYCLES && !t.land) begin
                n.m.jump = JUMP_FALL;
                n.cnt    = s.cnt + 1;
            end else begin
                n.m.jump = JUMP_GROUND;
                n.cnt    = 0;
            end
        end
        if (!act) begin
            n.m   = '{facing: FACE_STILL, jump: JUMP_GROUND};
            n.cnt = 0;
        end
        return n;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_level(input level_t got, input level_t exp);
        if (got !== exp) report_failure($sformatf("mismatch level got %h expected %h", got, exp));
    endtask

    task automatic check_phase(input phase_e got, input phase_e exp);
        if (got !== exp) report_failure($sformatf("mismatch phase got %h expected %h", got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch flag_cover got %h expected %h", got, exp));
        end
    endtask

    task automatic check_motion(input string name, input motion_t got, input motion_t exp);
        if (got !== exp) report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) report_failure($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    // New beam position and image addresses on every falling edge
    task automatic hold_keys(input logic [KEY_W-1:0] keys, input int cycles);
        logic [31:0] r;
        key_down = keys;
        repeat (cycles) begin
            r          = rand32();
            vga_h      = r[31] ? r[9:0] : COORD_W'(290 + int'(r[5:0]));  // Mostly near the rows
            vga_v      = r[31] ? r[19:10] : COORD_W'(70 + int'(r[14:6]));
            cover_addr = r[15:0] ^ r[31:16];
            map_addr   = r[30:14];
            @(negedge clk);
        end
    endtask

    task automatic press(input logic [KEY_W-1:0] keys);
        hold_keys(keys, 3);
        hold_keys('0, 2);
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (rst) begin
                m_level = level_t'(1);
                m_phase = PHASE_MENU;
                m_cover = 1'b1;
                m_open  = 1'b1;
                m_p1    = motion_ref(m_p1, 1'b0, '0, '0);
                m_p2    = motion_ref(m_p2, 1'b0, '0, '0);
            end else begin
                // Players see the phase from before this edge
                m_p1 = motion_ref(m_p1, m_phase == PHASE_PLAY, key_group(key_down, 4), p1_env);
                m_p2 = motion_ref(m_p2, m_phase == PHASE_PLAY, key_group(key_down, 0), p2_env);
                if (m_phase == PHASE_MENU) begin
                    if (key_down == '0) begin
                        m_open = 1'b1;
                    end else if (m_open && (key_down[0] || key_down[4])) begin
                        m_level = (m_level < NUM_LEVELS) ? level_t'(m_level + 1) : m_level;
                        m_open  = 1'b0;
                    end else if (m_open && (key_down[2] || key_down[6])) begin
                        m_level = (m_level > 1) ? level_t'(m_level - 1) : m_level;
                        m_open  = 1'b0;
                    end else if (m_open && key_down[8]) begin
                        m_phase = m_cover ? PHASE_MENU : PHASE_PLAY;
                        m_cover = 1'b0;
                        m_open  = 1'b0;
                    end
                end
                #1;
                check_level(level, m_level);
                check_phase(phase, m_phase);
                check_flag(flag_cover, m_cover);
                check_motion("p1_motion", p1_motion, m_p1.m);
                check_motion("p2_motion", p2_motion, m_p2.m);
                if (m_cover) exp_addr = ADDR_W'(cover_addr);
                else if (m_phase == PHASE_MENU) exp_addr = cursor_ref(vga_h, vga_v, m_level);
                else exp_addr = (m_level == 1) ? map_addr : '0;
                check_addr("pixel_addr", pixel_addr, exp_addr);
            end
        end
    end

    initial begin
        #(STIM_CYCLES * 10 + 2000);
        report_failure("watchdog expired before the stimulus finished");
    end

    initial begin
        logic [31:0] r;
        int          rise_len;
        rng        = 32'h173c_893d;
        rst        = 1'b1;
        key_down   = '0;
        vga_h      = '0;
        vga_v      = '0;
        cover_addr = '0;
        map_addr   = '0;
        p1_env     = '0;
        p2_env     = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        hold_keys('0, 4);
        press(10'h100);  // First start only drops the cover
        check_phase(phase, PHASE_MENU);
        repeat (6) press(10'h001);
        check_level(level, level_t'(NUM_LEVELS));
        repeat (6) press(10'h040);
        check_level(level, level_t'(1));
        hold_keys(10'h010, 30);
        hold_keys('0, 2);
        check_level(level, level_t'(2));
        repeat (100) begin
            r = rand32();
            hold_keys(r[9:0] & 10'h0ff, 1);  // Start key masked so the menu stays open
        end
        repeat (NUM_LEVELS) press(10'h004);
        for (int lv = 1; lv <= NUM_LEVELS; lv++) begin
            check_level(level, level_t'(lv));
            hold_keys('0, 400);
            press(10'h001);
        end
        repeat (NUM_LEVELS) press(10'h004);  // Level 1 is the one with a map image in play
        press(10'h100);
        check_phase(phase, PHASE_PLAY);
        press(10'h001);
        check_level(level, level_t'(1));
        hold_keys('0, AIR_CYCLES);
        rise_len = 0;
        repeat (RISE_CYCLES + 4) begin
            hold_keys(10'h011, 1);
            if (p1_motion.jump == JUMP_RISE) rise_len++;
        end
        if (rise_len != RISE_CYCLES) report_failure("player 1 rise length is not the rise limit");
        p1_env.land = 1'b1;
        p2_env.land = 1'b1;
        hold_keys(10'h011, 2);
        p1_env = '0;
        p2_env = '0;
        hold_keys('0, AIR_CYCLES);
        hold_keys(10'h011, 3);
        p1_env.collision = 1'b1;  // Ceiling hit in the middle of the rise
        hold_keys(10'h011, 2);
        p1_env = '0;
        hold_keys(10'h011, AIR_CYCLES);
        hold_keys('0, AIR_CYCLES);
        p1_env.should_down = 1'b1;
        p2_env.should_down = 1'b1;
        hold_keys(10'h028, 3);
        p1_env = '0;
        p2_env = '0;
        hold_keys(10'h028, AIR_CYCLES);
        repeat (600) begin
            r      = rand32();
            p1_env = terrain_t'(r[12:10] & r[15:13]);
            p2_env = terrain_t'(r[18:16] & r[21:19]);
            hold_keys(r[9:0], 1);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
